//--- common/cluster_cfg_pkg.sv
package cluster_cfg_pkg;

    // ************************************************************************
    // Cluster shape
    // ************************************************************************

    localparam int NUM_SOCKETS = 2;

    // ************************************************************************
    // DCR address map
    // ************************************************************************

    // Ranges are half open, begin inclusive and end exclusive

    // Socket base state
    localparam DCR_BASE_BEGIN = 12'h001;
    localparam DCR_BASE_END   = 12'h020;

    // Texture state
    localparam DCR_TEX_BEGIN  = 12'h020;
    localparam DCR_TEX_END    = 12'h040;

    // Render output state
    localparam DCR_ROP_BEGIN  = 12'h040;
    localparam DCR_ROP_END    = 12'h060;

    // Interrupt enable per socket, last word of the base range
    // Bit s of the data enables socket s
    localparam DCR_IRQ_MASK_ADDR = 12'h01F;

endpackage

//--- common/cluster_bus_pkg.sv
package cluster_bus_pkg;

    // ************************************************************************
    // DCR bus words
    // ************************************************************************

    localparam int DCR_ADDR_BITS = 12;
    localparam int DCR_DATA_BITS = 32;

    typedef logic [DCR_ADDR_BITS-1:0] dcr_addr_t;
    typedef logic [DCR_DATA_BITS-1:0] dcr_data_t;

    // ************************************************************************
    // Socket status port
    // ************************************************************************

    // Which status field a socket write targets
    typedef enum logic [1:0] {
        STATUS_ERR        = 2'd0,
        STATUS_PIPE_CLEAN = 2'd1,
        STATUS_EPC        = 2'd2
    } status_sel_t;

    // Error codes, anything nonzero counts as pending
    localparam int ERR_CODE_BITS = 8;

    typedef logic [ERR_CODE_BITS-1:0] err_code_t;

    localparam err_code_t ERR_NONE = '0;

    // Socket index for the interrupt report
    typedef logic [$clog2(cluster_cfg_pkg::NUM_SOCKETS)-1:0] sock_idx_t;

endpackage

//--- dcr/dcr_range_filter.sv
`timescale 1ns/1ps

module dcr_range_filter (
    input  logic                       clk,
    input  logic                       arst_n,

    // Host write
    input  logic                       dcr_wr_valid,
    input  cluster_bus_pkg::dcr_addr_t dcr_wr_addr,
    input  cluster_bus_pkg::dcr_data_t dcr_wr_data,

    // One strobe per range, registered
    output logic                       sock_dcr_wr_valid,
    output logic                       tex_dcr_wr_valid,
    output logic                       rop_dcr_wr_valid,
    output cluster_bus_pkg::dcr_addr_t dcr_out_addr,
    output cluster_bus_pkg::dcr_data_t dcr_out_data
);

    import cluster_cfg_pkg::*;
    import cluster_bus_pkg::*;

    logic base_hit;
    logic tex_hit;
    logic rop_hit;
    logic any_hit;

    function automatic logic addr_in_range(
        input dcr_addr_t addr,
        input dcr_addr_t range_begin,
        input dcr_addr_t range_end
    );
        return (addr >= range_begin) && (addr < range_end);
    endfunction

    // ************************************************************************
    // Address decode
    // ************************************************************************

    assign base_hit = dcr_wr_valid && addr_in_range(dcr_wr_addr, DCR_BASE_BEGIN, DCR_BASE_END);
    assign tex_hit  = dcr_wr_valid && addr_in_range(dcr_wr_addr, DCR_TEX_BEGIN, DCR_TEX_END);
    assign rop_hit  = dcr_wr_valid && addr_in_range(dcr_wr_addr, DCR_ROP_BEGIN, DCR_ROP_END);

    // Ranges do not overlap, so at most one is set
    assign any_hit  = base_hit || tex_hit || rop_hit;

    // ************************************************************************
    // Output stage
    // ************************************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sock_dcr_wr_valid <= 1'b0;
            tex_dcr_wr_valid  <= 1'b0;
            rop_dcr_wr_valid  <= 1'b0;
        end else begin
            sock_dcr_wr_valid <= base_hit;
            tex_dcr_wr_valid  <= tex_hit;
            rop_dcr_wr_valid  <= rop_hit;
        end
    end

    // Word holds until the next routed write
    always_ff @(posedge clk) begin
        if (any_hit) begin
            dcr_out_addr <= dcr_wr_addr;
            dcr_out_data <= dcr_wr_data;
        end
    end

endmodule

//--- src/status_regs.sv
`timescale 1ns/1ps

module status_regs (
    input  logic                                                     clk,
    input  logic                                                     arst_n,

    // Status write port, one lane per socket
    input  logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  status_wr_valid,
    input  cluster_bus_pkg::status_sel_t [cluster_cfg_pkg::NUM_SOCKETS-1:0] status_wr_sel,
    input  cluster_bus_pkg::dcr_data_t [cluster_cfg_pkg::NUM_SOCKETS-1:0]   status_wr_data,

    // One-hot clear from the interrupt controller
    input  logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  err_clear,

    output logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  err_pending,
    output cluster_bus_pkg::err_code_t [cluster_cfg_pkg::NUM_SOCKETS-1:0]   err_code,
    output logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  pipe_clean,
    output cluster_bus_pkg::dcr_data_t [cluster_cfg_pkg::NUM_SOCKETS-1:0]   epc
);

    import cluster_cfg_pkg::*;
    import cluster_bus_pkg::*;

    // ************************************************************************
    // Per-socket register set
    // ************************************************************************

    for (genvar s = 0; s < NUM_SOCKETS; s++) begin : g_sock

        logic      err_wr;
        err_code_t err_wr_code;

        assign err_wr      = status_wr_valid[s] && (status_wr_sel[s] == STATUS_ERR);
        assign err_wr_code = status_wr_data[s][ERR_CODE_BITS-1:0];

        // A new error landing with the clear takes priority
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                err_code[s] <= ERR_NONE;
            end else if (err_wr) begin
                err_code[s] <= err_wr_code;
            end else if (err_clear[s]) begin
                err_code[s] <= ERR_NONE;
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                pipe_clean[s] <= 1'b0;
                epc[s]        <= '0;
            end else if (status_wr_valid[s]) begin
                case (status_wr_sel[s])
                    STATUS_PIPE_CLEAN: pipe_clean[s] <= status_wr_data[s][0];
                    STATUS_EPC:        epc[s]        <= status_wr_data[s];
                    // Error writes handled above, selector 3 dropped
                    default: ;
                endcase
            end
        end

        assign err_pending[s] = (err_code[s] != ERR_NONE);

    end

endmodule

//--- src/interrupt_ctl.sv
`timescale 1ns/1ps

module interrupt_ctl (
    input  logic                                                     clk,
    input  logic                                                     arst_n,

    // Base range DCR writes, after the filter
    input  logic                                                     sock_dcr_wr_valid,
    input  cluster_bus_pkg::dcr_addr_t                               dcr_out_addr,
    input  cluster_bus_pkg::dcr_data_t                               dcr_out_data,

    // Socket status
    input  logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  err_pending,
    input  cluster_bus_pkg::err_code_t [cluster_cfg_pkg::NUM_SOCKETS-1:0]   err_code,
    input  cluster_bus_pkg::dcr_data_t [cluster_cfg_pkg::NUM_SOCKETS-1:0]   epc,

    input  logic                                                     irq_ack,
    input  logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  socket_busy,

    output logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  err_clear,
    output logic                                                     irq,
    output cluster_bus_pkg::sock_idx_t                               irq_socket,
    output cluster_bus_pkg::err_code_t                               irq_cause,
    output cluster_bus_pkg::dcr_data_t                               irq_epc,
    output logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  irq_mask,
    output logic                                                     busy
);

    import cluster_cfg_pkg::*;
    import cluster_bus_pkg::*;

    logic      mask_wr;
    logic      sel_valid;
    sock_idx_t sel_idx;

    // ************************************************************************
    // Interrupt mask
    // ************************************************************************

    assign mask_wr = sock_dcr_wr_valid && (dcr_out_addr == DCR_IRQ_MASK_ADDR);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_mask <= '0;
        end else if (mask_wr) begin
            irq_mask <= dcr_out_data[NUM_SOCKETS-1:0];
        end
    end

    // ************************************************************************
    // Priority select and report
    // ************************************************************************

    // Scan downwards so the lowest enabled socket is kept
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        for (int s = NUM_SOCKETS - 1; s >= 0; s--) begin
            if (err_pending[s] && irq_mask[s]) begin
                sel_valid = 1'b1;
                sel_idx   = sock_idx_t'(s);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        irq_socket <= sel_idx;
        irq_cause  <= err_code[sel_idx];
        irq_epc    <= epc[sel_idx];
    end

    // Ack clears the socket currently reported
    always_comb begin
        err_clear = '0;
        if (irq && irq_ack) begin
            err_clear[irq_socket] = 1'b1;
        end
    end

    // ************************************************************************
    // Cluster busy
    // ************************************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= |socket_busy;
        end
    end

endmodule

//--- src/cluster_ctrl.sv
`timescale 1ns/1ps

module cluster_ctrl (
    input  logic                                                     clk,
    input  logic                                                     arst_n,

    // Host DCR write
    input  logic                                                     dcr_wr_valid,
    input  cluster_bus_pkg::dcr_addr_t                               dcr_wr_addr,
    input  cluster_bus_pkg::dcr_data_t                               dcr_wr_data,

    // Routed DCR writes
    output logic                                                     sock_dcr_wr_valid,
    output logic                                                     tex_dcr_wr_valid,
    output logic                                                     rop_dcr_wr_valid,
    output cluster_bus_pkg::dcr_addr_t                               dcr_out_addr,
    output cluster_bus_pkg::dcr_data_t                               dcr_out_data,

    // Socket side
    input  logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  status_wr_valid,
    input  cluster_bus_pkg::status_sel_t [cluster_cfg_pkg::NUM_SOCKETS-1:0] status_wr_sel,
    input  cluster_bus_pkg::dcr_data_t [cluster_cfg_pkg::NUM_SOCKETS-1:0]   status_wr_data,
    input  logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  socket_busy,

    // Interrupt to host
    input  logic                                                     irq_ack,
    output logic                                                     irq,
    output cluster_bus_pkg::sock_idx_t                               irq_socket,
    output cluster_bus_pkg::err_code_t                               irq_cause,
    output cluster_bus_pkg::dcr_data_t                               irq_epc,
    output logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  irq_mask,

    output logic [cluster_cfg_pkg::NUM_SOCKETS-1:0]                  pipe_clean,
    output logic                                                     busy
);

    import cluster_cfg_pkg::*;
    import cluster_bus_pkg::*;

    logic [NUM_SOCKETS-1:0]      err_pending;
    logic [NUM_SOCKETS-1:0]      err_clear;
    err_code_t [NUM_SOCKETS-1:0] err_code;
    dcr_data_t [NUM_SOCKETS-1:0] epc;

    dcr_range_filter u_dcr_range_filter (
        .clk               (clk),
        .arst_n            (arst_n),
        .dcr_wr_valid      (dcr_wr_valid),
        .dcr_wr_addr       (dcr_wr_addr),
        .dcr_wr_data       (dcr_wr_data),
        .sock_dcr_wr_valid (sock_dcr_wr_valid),
        .tex_dcr_wr_valid  (tex_dcr_wr_valid),
        .rop_dcr_wr_valid  (rop_dcr_wr_valid),
        .dcr_out_addr      (dcr_out_addr),
        .dcr_out_data      (dcr_out_data)
    );

    status_regs u_status_regs (
        .clk             (clk),
        .arst_n          (arst_n),
        .status_wr_valid (status_wr_valid),
        .status_wr_sel   (status_wr_sel),
        .status_wr_data  (status_wr_data),
        .err_clear       (err_clear),
        .err_pending     (err_pending),
        .err_code        (err_code),
        .pipe_clean      (pipe_clean),
        .epc             (epc)
    );

    interrupt_ctl u_interrupt_ctl (
        .clk               (clk),
        .arst_n            (arst_n),
        .sock_dcr_wr_valid (sock_dcr_wr_valid),
        .dcr_out_addr      (dcr_out_addr),
        .dcr_out_data      (dcr_out_data),
        .err_pending       (err_pending),
        .err_code          (err_code),
        .epc               (epc),
        .irq_ack           (irq_ack),
        .socket_busy       (socket_busy),
        .err_clear         (err_clear),
        .irq               (irq),
        .irq_socket        (irq_socket),
        .irq_cause         (irq_cause),
        .irq_epc           (irq_epc),
        .irq_mask          (irq_mask),
        .busy              (busy)
    );

endmodule

//--- testbench/cluster_ctrl_asserts.sv
`timescale 1ns/1ps

module cluster_ctrl_asserts (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    dcr_wr_valid,
    input  logic                                    sock_dcr_wr_valid,
    input  logic                                    tex_dcr_wr_valid,
    input  logic                                    rop_dcr_wr_valid,
    input  logic                                    irq,
    input  cluster_bus_pkg::sock_idx_t              irq_socket,
    input  logic [cluster_cfg_pkg::NUM_SOCKETS-1:0] irq_mask
);

    logic [2:0]  strobes;
    int unsigned fail_count = 0;

    assign strobes = {sock_dcr_wr_valid, tex_dcr_wr_valid, rop_dcr_wr_valid};

    // Ranges are disjoint
    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(strobes))
        else begin
            fail_count++;
            $error("more than one DCR range strobe is high");
        end

    a_irq_unmasked: assert property (@(posedge clk) disable iff (!arst_n)
        irq |-> irq_mask[irq_socket])
        else begin
            fail_count++;
            $error("irq raised for a masked socket");
        end

    // Filter latency is exactly one cycle
    a_strobe_after_write: assert property (@(posedge clk) disable iff (!arst_n)
        (|strobes) |-> $past(dcr_wr_valid))
        else begin
            fail_count++;
            $error("range strobe without a host write one cycle before");
        end

endmodule

bind cluster_ctrl cluster_ctrl_asserts u_cluster_ctrl_asserts (.*);

//--- testbench/tb_cluster_ctrl.sv
`timescale 1ns/1ps

module tb_cluster_ctrl;

    import cluster_cfg_pkg::*;
    import cluster_bus_pkg::*;

    localparam int IRQ_TIMEOUT = 20;

    logic                        clk;
    logic                        arst_n;
    logic                        dcr_wr_valid;
    dcr_addr_t                   dcr_wr_addr;
    dcr_data_t                   dcr_wr_data;
    logic                        sock_dcr_wr_valid;
    logic                        tex_dcr_wr_valid;
    logic                        rop_dcr_wr_valid;
    dcr_addr_t                   dcr_out_addr;
    dcr_data_t                   dcr_out_data;
    logic [NUM_SOCKETS-1:0]      status_wr_valid;
    status_sel_t [NUM_SOCKETS-1:0] status_wr_sel;
    dcr_data_t [NUM_SOCKETS-1:0] status_wr_data;
    logic [NUM_SOCKETS-1:0]      socket_busy;
    logic                        irq_ack;
    logic                        irq;
    sock_idx_t                   irq_socket;
    err_code_t                   irq_cause;
    dcr_data_t                   irq_epc;
    logic [NUM_SOCKETS-1:0]      irq_mask;
    logic [NUM_SOCKETS-1:0]      pipe_clean;
    logic                        busy;
    logic [31:0]                 lfsr_state;

    cluster_ctrl dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
            stop_with_failure("value check failed");
        end
    endtask

    // Bound checker failures end the run at the next falling edge
    always @(negedge clk) begin
        assert (dut.u_cluster_ctrl_asserts.fail_count == 0) else begin
            stop_with_failure("a concurrent assertion on cluster_ctrl failed");
        end
    end

    // ************************************************************************
    // Stimulus helpers
    // ************************************************************************

    // Fibonacci LFSR with taps 32 22 2 1
    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic random_error(output dcr_data_t word);
        word = rand_bits(32);
        if (word[7:0] == ERR_NONE) begin
            word[7:0] = 8'h01;
        end
    endtask

    task automatic dcr_write(input dcr_addr_t addr, input dcr_data_t data);
        @(negedge clk);
        dcr_wr_valid = 1'b1;
        dcr_wr_addr  = addr;
        dcr_wr_data  = data;
        @(negedge clk);
        dcr_wr_valid = 1'b0;
    endtask

    task automatic status_write(input logic [NUM_SOCKETS-1:0] lanes, input status_sel_t sel,
                                input dcr_data_t [NUM_SOCKETS-1:0] data);
        @(negedge clk);
        status_wr_valid = lanes;
        for (int s = 0; s < NUM_SOCKETS; s++) begin
            status_wr_sel[s] = sel;
        end
        status_wr_data = data;
        @(negedge clk);
        status_wr_valid = '0;
    endtask

    task automatic set_mask(input logic [NUM_SOCKETS-1:0] mask);
        dcr_write(DCR_IRQ_MASK_ADDR, dcr_data_t'(mask));
        @(negedge clk);
        check_value("irq_mask", irq_mask, mask);
    endtask

    task automatic ack_irq();
        @(negedge clk);
        check_value("irq", irq, 1'b1);
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
    endtask

    task automatic wait_for_irq(input logic level, input sock_idx_t sock, input string what);
        logic seen;
        seen = 1'b0;
        for (int cycles = 0; cycles < IRQ_TIMEOUT && !seen; cycles++) begin
            @(negedge clk);
            seen = (irq === level) && (!level || irq_socket === sock);
        end
        assert (seen) else begin
            stop_with_failure({"timeout waiting for ", what});
        end
    endtask

    task automatic expect_irq_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("irq", irq, 1'b0);
        end
    endtask

    // ************************************************************************
    // Directed tests
    // ************************************************************************

    task automatic test_reset_state();
        check_value("range strobes", {sock_dcr_wr_valid, tex_dcr_wr_valid, rop_dcr_wr_valid}, 0);
        check_value("irq", irq, 1'b0);
        check_value("busy", busy, 1'b0);
        check_value("irq_mask", irq_mask, 0);
        check_value("pipe_clean", pipe_clean, 0);
    endtask

    // Expected strobes packed as sock, tex, rop
    task automatic route_check(input dcr_addr_t addr, input logic [2:0] expected);
        dcr_data_t data;
        data = rand_bits(32);
        dcr_write(addr, data);
        check_value("sock_dcr_wr_valid", sock_dcr_wr_valid, expected[2]);
        check_value("tex_dcr_wr_valid", tex_dcr_wr_valid, expected[1]);
        check_value("rop_dcr_wr_valid", rop_dcr_wr_valid, expected[0]);
        if (expected != 3'b000) begin
            check_value("dcr_out_addr", dcr_out_addr, addr);
            check_value("dcr_out_data", dcr_out_data, data);
        end
        @(negedge clk);
        check_value("range strobes", {sock_dcr_wr_valid, tex_dcr_wr_valid, rop_dcr_wr_valid}, 0);
    endtask

    task automatic test_range_routing();
        route_check(DCR_BASE_BEGIN, 3'b100);
        route_check(DCR_BASE_END - 12'h001, 3'b100);
        route_check(DCR_TEX_BEGIN, 3'b010);
        route_check(DCR_TEX_END - 12'h001, 3'b010);
        route_check(DCR_ROP_BEGIN, 3'b001);
        route_check(DCR_ROP_END - 12'h001, 3'b001);
        route_check(12'h000, 3'b000);
        route_check(12'h060, 3'b000);
    endtask

    task automatic test_busy();
        for (int p = 0; p <= 4; p++) begin
            @(negedge clk);
            socket_busy = NUM_SOCKETS'(p);
            @(negedge clk);
            check_value("busy", busy, (NUM_SOCKETS'(p) != 0));
        end
    endtask

    task automatic test_masking();
        dcr_data_t [NUM_SOCKETS-1:0] words;
        dcr_data_t                   epc_exp;
        words = '0;
        set_mask('0);
        words[1] = rand_bits(32);
        epc_exp = words[1];
        status_write(2'b10, STATUS_EPC, words);
        random_error(words[1]);
        status_write(2'b10, STATUS_ERR, words);
        expect_irq_quiet(6);
        set_mask(2'b10);
        wait_for_irq(1'b1, 1'b1, "irq from socket 1 after unmasking");
        check_value("irq_cause", irq_cause, words[1][7:0]);
        check_value("irq_epc", irq_epc, epc_exp);
        ack_irq();
        wait_for_irq(1'b0, 1'b0, "irq to fall after ack");
    endtask

    task automatic test_priority();
        dcr_data_t [NUM_SOCKETS-1:0] epcs;
        dcr_data_t [NUM_SOCKETS-1:0] errs;
        set_mask(2'b11);
        epcs[0] = rand_bits(32);
        epcs[1] = rand_bits(32);
        random_error(errs[0]);
        random_error(errs[1]);
        status_write(2'b11, STATUS_EPC, epcs);
        status_write(2'b11, STATUS_ERR, errs);
        // Lowest socket first
        wait_for_irq(1'b1, 1'b0, "irq from socket 0");
        check_value("irq_cause", irq_cause, errs[0][7:0]);
        check_value("irq_epc", irq_epc, epcs[0]);
        ack_irq();
        wait_for_irq(1'b1, 1'b1, "irq to move to socket 1");
        check_value("irq_cause", irq_cause, errs[1][7:0]);
        check_value("irq_epc", irq_epc, epcs[1]);
        ack_irq();
        wait_for_irq(1'b0, 1'b0, "irq to fall after second ack");
    endtask

    task automatic test_pipe_clean();
        dcr_data_t [NUM_SOCKETS-1:0] words;
        words = '0;
        words[1] = rand_bits(32);
        words[1][0] = 1'b1;
        status_write(2'b10, STATUS_PIPE_CLEAN, words);
        check_value("pipe_clean", pipe_clean, 2'b10);
        expect_irq_quiet(4);
        words[1][0] = 1'b0;
        status_write(2'b10, STATUS_PIPE_CLEAN, words);
        check_value("pipe_clean", pipe_clean, 2'b00);
    endtask

    initial begin
        lfsr_state      = 32'h6e71_67e1;
        arst_n          = 1'b0;
        dcr_wr_valid    = 1'b0;
        dcr_wr_addr     = '0;
        dcr_wr_data     = '0;
        status_wr_valid = '0;
        status_wr_data  = '0;
        socket_busy     = '0;
        irq_ack         = 1'b0;
        for (int s = 0; s < NUM_SOCKETS; s++) begin
            status_wr_sel[s] = STATUS_ERR;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_reset_state();
        test_range_routing();
        test_busy();
        test_masking();
        test_priority();
        test_pipe_clean();

        if (dut.u_cluster_ctrl_asserts.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_with_failure("a concurrent assertion on cluster_ctrl failed");
        end
    end

endmodule

//--- compile.f
common/cluster_cfg_pkg.sv
common/cluster_bus_pkg.sv
dcr/dcr_range_filter.sv
src/status_regs.sv
src/interrupt_ctl.sv
src/cluster_ctrl.sv
testbench/cluster_ctrl_asserts.sv
testbench/tb_cluster_ctrl.sv

//--- Bender.yml
package:
  name: cluster_ctrl

sources:
  # Packages before the modules that import them
  - common/cluster_cfg_pkg.sv
  - common/cluster_bus_pkg.sv
  - dcr/dcr_range_filter.sv
  - src/status_regs.sv
  - src/interrupt_ctl.sv
  - src/cluster_ctrl.sv

  - target: test
    files:
      - testbench/cluster_ctrl_asserts.sv
      - testbench/tb_cluster_ctrl.sv
